// ==== hdl/mips_pkg.sv ====
package mips_pkg;

   // width types
   typedef logic [31:0] word_t;    // data word
   typedef logic [29:0] waddr_t;   // word address, byte offset dropped
   typedef logic [4:0]  reg_idx_t; // register number
   typedef logic [5:0]  opcode_t;  // inst[31:26]
   typedef logic [5:0]  funct_t;   // inst[5:0], R-type only

   // alu operations
   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_nor,
      alu_slt,  // signed
      alu_sll,
      alu_srl,
      alu_sra,
      alu_lui   // imm into upper half
   } alu_op_e;

   // write-back source
   typedef enum logic [1:0] {
      wb_alu,
      wb_mem,
      wb_link   // pc+4 for jal
   } wb_sel_e;

   // next pc source
   typedef enum logic [1:0] {
      pc_seq,
      pc_branch,  // taken or not, pc unit decides
      pc_jump,
      pc_reg      // jr
   } pc_sel_e;

   // primary opcodes
   localparam opcode_t op_rtype = 6'h00;
   localparam opcode_t op_j     = 6'h02;
   localparam opcode_t op_jal   = 6'h03;
   localparam opcode_t op_beq   = 6'h04;
   localparam opcode_t op_bne   = 6'h05;
   localparam opcode_t op_addi  = 6'h08;
   localparam opcode_t op_addiu = 6'h09;
   localparam opcode_t op_slti  = 6'h0a;
   localparam opcode_t op_andi  = 6'h0c;
   localparam opcode_t op_ori   = 6'h0d;
   localparam opcode_t op_xori  = 6'h0e;
   localparam opcode_t op_lui   = 6'h0f;
   localparam opcode_t op_lw    = 6'h23;
   localparam opcode_t op_sw    = 6'h2b;

   // R-type funct codes
   localparam funct_t fn_sll     = 6'h00;
   localparam funct_t fn_srl     = 6'h02;
   localparam funct_t fn_sra     = 6'h03;
   localparam funct_t fn_jr      = 6'h08;
   localparam funct_t fn_syscall = 6'h0c;
   localparam funct_t fn_add     = 6'h20;
   localparam funct_t fn_addu    = 6'h21;
   localparam funct_t fn_sub     = 6'h22;
   localparam funct_t fn_subu    = 6'h23;
   localparam funct_t fn_and     = 6'h24;
   localparam funct_t fn_or      = 6'h25;
   localparam funct_t fn_xor     = 6'h26;
   localparam funct_t fn_nor     = 6'h27;
   localparam funct_t fn_slt     = 6'h2a;

   localparam reg_idx_t reg_v0 = 5'd2;   // syscall number
   localparam reg_idx_t reg_ra = 5'd31;  // jal link
   localparam word_t syscall_exit = 32'd10;

endpackage

// ==== hdl/mips_decode.sv ====
`timescale 1ns/10ps

module mips_decode (
   input  mips_pkg::opcode_t opcode,
   input  mips_pkg::funct_t  funct,
   input  logic              v0_is_exit,  // $v0 == 10
   output mips_pkg::alu_op_e alu_op,
   output logic              reg_write,
   output logic              dst_is_rd,    // else rt
   output logic              imm_signed,
   output logic              alu_src_imm,  // op_b from immediate
   output mips_pkg::wb_sel_e wb_sel,
   output logic              mem_write,
   output logic              branch_ne,    // bne sense
   output logic              is_branch,
   output mips_pkg::pc_sel_e pc_sel,
   output logic              halt_req
);
   import mips_pkg::*;

   always_comb begin
      // safe defaults, nothing written
      alu_op      = alu_add;
      reg_write   = 1'b0;
      dst_is_rd   = 1'b0;
      imm_signed  = 1'b1;
      alu_src_imm = 1'b0;
      wb_sel      = wb_alu;
      mem_write   = 1'b0;
      branch_ne   = 1'b0;
      is_branch   = 1'b0;
      pc_sel      = pc_seq;
      halt_req    = 1'b0;

      case (opcode)
         op_rtype: begin
            reg_write = 1'b1;  // cleared below for jr, syscall
            dst_is_rd = 1'b1;
            case (funct)
               fn_add, fn_addu: alu_op = alu_add;  // no overflow trap
               fn_sub, fn_subu: alu_op = alu_sub;
               fn_and:          alu_op = alu_and;
               fn_or:           alu_op = alu_or;
               fn_xor:          alu_op = alu_xor;
               fn_nor:          alu_op = alu_nor;
               fn_slt:          alu_op = alu_slt;
               fn_sll:          alu_op = alu_sll;
               fn_srl:          alu_op = alu_srl;
               fn_sra:          alu_op = alu_sra;
               fn_jr: begin
                  reg_write = 1'b0;
                  pc_sel    = pc_reg;
               end
               fn_syscall: begin
                  reg_write = 1'b0;
                  halt_req  = v0_is_exit;  // other codes fall through
               end
               default: begin
                  reg_write = 1'b0;  // reserved funct
                  halt_req  = 1'b1;
               end
            endcase
         end
         op_addi, op_addiu: begin
            reg_write   = 1'b1;
            alu_src_imm = 1'b1;
         end
         op_slti: begin
            alu_op      = alu_slt;
            reg_write   = 1'b1;
            alu_src_imm = 1'b1;
         end
         op_andi, op_ori, op_xori: begin
            reg_write   = 1'b1;
            alu_src_imm = 1'b1;
            imm_signed  = 1'b0;  // logical imms zero-extend
            alu_op      = (opcode == op_andi) ? alu_and :
                          (opcode == op_ori)  ? alu_or  : alu_xor;
         end
         op_lui: begin
            alu_op      = alu_lui;
            reg_write   = 1'b1;
            alu_src_imm = 1'b1;
         end
         op_lw: begin
            reg_write   = 1'b1;
            alu_src_imm = 1'b1;  // base + offset
            wb_sel      = wb_mem;
         end
         op_sw: begin
            alu_src_imm = 1'b1;
            mem_write   = 1'b1;
         end
         op_beq, op_bne: begin
            alu_op    = alu_sub;  // rs - rt, zero flag compares
            is_branch = 1'b1;
            branch_ne = (opcode == op_bne);
            pc_sel    = pc_branch;
         end
         op_j: pc_sel = pc_jump;
         op_jal: begin
            pc_sel    = pc_jump;
            reg_write = 1'b1;
            wb_sel    = wb_link;  // dest forced to $ra in core
         end
         default: halt_req = 1'b1;  // reserved opcode
      endcase
   end

endmodule

// ==== hdl/mips_alu.sv ====
`timescale 1ns/10ps

module mips_alu (
   input  mips_pkg::word_t   op_a,   // rs
   input  mips_pkg::word_t   op_b,   // rt or imm
   input  logic [4:0]        shamt,
   input  mips_pkg::alu_op_e alu_op,
   output mips_pkg::word_t   result,
   output logic              zero
);
   import mips_pkg::*;

   word_t diff;  // shared by sub and slt

   assign diff = op_a - op_b;

   always_comb begin
      case (alu_op)
         alu_add: result = op_a + op_b;
         alu_sub: result = diff;
         alu_and: result = op_a & op_b;
         alu_or:  result = op_a | op_b;
         alu_xor: result = op_a ^ op_b;
         alu_nor: result = ~(op_a | op_b);
         alu_slt: begin
            // signs differ -> a negative wins, else look at diff sign
            if (op_a[31] != op_b[31])
               result = {31'b0, op_a[31]};
            else
               result = {31'b0, diff[31]};
         end
         alu_sll: result = op_b << shamt;
         alu_srl: result = op_b >> shamt;
         alu_sra: result = word_t'($signed(op_b) >>> shamt);  // keep sign bit
         alu_lui: result = {op_b[15:0], 16'h0000};
         default: result = '0;
      endcase
   end

   assign zero = (result == '0);  // beq/bne via alu_sub

endmodule

// ==== hdl/mips_regfile.sv ====
`timescale 1ns/10ps

module mips_regfile (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs,
   input  mips_pkg::reg_idx_t rt,
   input  logic               wr_en,
   input  mips_pkg::reg_idx_t wr_idx,
   input  mips_pkg::word_t    wr_data,
   output mips_pkg::word_t    rs_data,
   output mips_pkg::word_t    rt_data,
   output logic               v0_is_exit
);
   import mips_pkg::*;

   word_t regs [32];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_idx != 5'd0)) begin  // $zero stays 0
         regs[wr_idx] <= wr_data;
      end
   end

   // combinational reads, new value seen after the edge
   assign rs_data = regs[rs];
   assign rt_data = regs[rt];

   // syscall exit code check for decode
   assign v0_is_exit = (regs[reg_v0] == syscall_exit);

endmodule

// ==== hdl/mips_pc_unit.sv ====
`timescale 1ns/10ps

module mips_pc_unit #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic              clk,
   input  logic              rst_b,
   input  mips_pkg::pc_sel_e pc_sel,
   input  logic              is_branch,
   input  logic              branch_ne,
   input  logic              alu_zero,   // rs == rt
   input  logic [15:0]       imm,        // branch offset, words
   input  logic [25:0]       target,     // jump target, words
   input  mips_pkg::word_t   rs_data,    // jr target
   input  logic              halt_req,
   output mips_pkg::word_t   pc,
   output mips_pkg::word_t   pc_plus4,
   output logic              halted
);
   import mips_pkg::*;

   word_t br_target;
   word_t j_target;
   word_t next_pc;
   logic  br_taken;

   assign pc_plus4  = pc + 32'd4;
   assign br_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
   assign j_target  = {pc[31:28], target, 2'b00};  // same 256MB region

   // beq wants zero, bne wants nonzero
   assign br_taken = is_branch && (alu_zero != branch_ne);

   always_comb begin
      case (pc_sel)
         pc_branch: next_pc = br_taken ? br_target : pc_plus4;
         pc_jump:   next_pc = j_target;
         pc_reg:    next_pc = rs_data;
         default:   next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= text_start;
         halted <= 1'b0;
      end else begin
         if (halt_req)
            halted <= 1'b1;  // sticky until reset
         // halting inst keeps its own address
         if (!halted && !halt_req)
            pc <= next_pc;
      end
   end

endmodule

// ==== hdl/mips_core.sv ====
`timescale 1ns/10ps

module mips_core #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000  // reset pc
) (
   input  logic             clk,
   input  logic             rst_b,
   input  mips_pkg::word_t  inst,
   input  mips_pkg::word_t  mem_data_out,
   output mips_pkg::waddr_t inst_addr,
   output mips_pkg::waddr_t mem_addr,
   output mips_pkg::word_t  mem_data_in,
   output logic [3:0]       mem_write_en,  // all or nothing, word stores only
   output logic             halted
);
   import mips_pkg::*;

   // instruction fields
   opcode_t     opcode;
   funct_t      funct;
   reg_idx_t    rs, rt, rd;
   logic [4:0]  shamt;
   logic [15:0] imm16;
   logic [25:0] target;
   word_t       imm_ext;

   // decode levels
   alu_op_e alu_op;
   wb_sel_e wb_sel;
   pc_sel_e pc_sel;
   logic    reg_write, dst_is_rd, imm_signed, alu_src_imm;
   logic    mem_write, branch_ne, is_branch, halt_req;

   // datapath
   word_t    pc, pc_plus4;
   word_t    rs_data, rt_data;
   word_t    alu_b, alu_result;
   word_t    wr_data;
   reg_idx_t wr_idx;
   logic     alu_zero, v0_is_exit;

   assign opcode = inst[31:26];
   assign rs     = inst[25:21];
   assign rt     = inst[20:16];
   assign rd     = inst[15:11];
   assign shamt  = inst[10:6];
   assign funct  = inst[5:0];
   assign imm16  = inst[15:0];
   assign target = inst[25:0];

   assign imm_ext = imm_signed ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
   assign alu_b   = alu_src_imm ? imm_ext : rt_data;

   // jal always links into $ra
   assign wr_idx = (wb_sel == wb_link) ? reg_ra : (dst_is_rd ? rd : rt);

   always_comb begin
      case (wb_sel)
         wb_mem:  wr_data = mem_data_out;  // lw
         wb_link: wr_data = pc_plus4;      // no delay slot
         default: wr_data = alu_result;
      endcase
   end

   assign inst_addr    = pc[31:2];
   assign mem_addr     = alu_result[31:2];  // base + offset
   assign mem_data_in  = rt_data;
   assign mem_write_en = {4{mem_write & ~halted}};

   mips_decode u_decode (
      .opcode, .funct, .v0_is_exit,
      .alu_op, .reg_write, .dst_is_rd, .imm_signed, .alu_src_imm,
      .wb_sel, .mem_write, .branch_ne, .is_branch, .pc_sel, .halt_req
   );

   mips_alu u_alu (
      .op_a   (rs_data),
      .op_b   (alu_b),
      .shamt  (shamt),
      .alu_op (alu_op),
      .result (alu_result),
      .zero   (alu_zero)
   );

   mips_regfile u_regfile (
      .clk, .rst_b, .rs, .rt,
      .wr_en      (reg_write & ~halted),  // frozen once halted
      .wr_idx     (wr_idx),
      .wr_data    (wr_data),
      .rs_data    (rs_data),
      .rt_data    (rt_data),
      .v0_is_exit (v0_is_exit)
   );

   mips_pc_unit #(.text_start(text_start)) u_pc (
      .clk, .rst_b, .pc_sel, .is_branch, .branch_ne, .alu_zero,
      .imm      (imm16),
      .target   (target),
      .rs_data  (rs_data),
      .halt_req (halt_req),
      .pc       (pc),
      .pc_plus4 (pc_plus4),
      .halted   (halted)
   );

endmodule

// ==== dv/mips_core_props.sv ====
`timescale 1ns/10ps

module mips_core_props (
   input logic             clk,
   input logic             rst_b,
   input mips_pkg::waddr_t inst_addr,
   input logic [3:0]       mem_write_en,
   input logic             halted
);

   // no store once stopped
   store_off_halted: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> (mem_write_en == 4'b0000))
      else $error("mem_write_en active while halted");

   pc_frozen: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> $stable(inst_addr))
      else $error("inst_addr moved while halted");

   // only reset clears the halt flop
   halt_sticky: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> halted)
      else $error("halted dropped without reset");

endmodule

bind mips_core mips_core_props u_props (.clk, .rst_b, .inst_addr, .mem_write_en, .halted);

// ==== dv/mips_tests.svh ====
// every kept ALU op on random operands, results stored from word 100 up
task automatic alu_ops_test();
   int         base = 100;
   word_t      a, b, r, simm, zimm;
   word_t      ops [16];
   word_t      expected [16];
   logic [4:0] sh;
   bit         done;
   a    = next_random();
   b    = next_random();
   r    = next_random();
   sh   = r[20:16];
   simm = {{16{r[15]}}, r[15:0]};
   zimm = {16'h0, r[15:0]};
   ops[0]  = rtype_word(fn_add, r_a, r_b, r_res, 5'd0);
   ops[1]  = rtype_word(fn_sub, r_a, r_b, r_res, 5'd0);
   ops[2]  = rtype_word(fn_and, r_a, r_b, r_res, 5'd0);
   ops[3]  = rtype_word(fn_or, r_a, r_b, r_res, 5'd0);
   ops[4]  = rtype_word(fn_xor, r_a, r_b, r_res, 5'd0);
   ops[5]  = rtype_word(fn_nor, r_a, r_b, r_res, 5'd0);
   ops[6]  = rtype_word(fn_slt, r_a, r_b, r_res, 5'd0);
   ops[7]  = itype_word(op_slti, r_a, r_res, r[15:0]);
   ops[8]  = rtype_word(fn_sll, r_zero, r_b, r_res, sh);  // shifts act on rt
   ops[9]  = rtype_word(fn_srl, r_zero, r_b, r_res, sh);
   ops[10] = rtype_word(fn_sra, r_zero, r_b, r_res, sh);
   ops[11] = itype_word(op_andi, r_a, r_res, r[15:0]);
   ops[12] = itype_word(op_xori, r_a, r_res, r[15:0]);
   ops[13] = itype_word(op_addiu, r_a, r_res, r[15:0]);
   expected[0]  = a + b;
   expected[1]  = a - b;
   expected[2]  = a & b;
   expected[3]  = a | b;
   expected[4]  = a ^ b;
   expected[5]  = ~(a | b);
   expected[6]  = {31'b0, $signed(a) < $signed(b)};
   expected[7]  = {31'b0, $signed(a) < $signed(simm)};
   expected[8]  = b << sh;
   expected[9]  = b >> sh;
   expected[10] = $signed(b) >>> sh;
   expected[11] = a & zimm;  // logical imms zero-extend
   expected[12] = a ^ zimm;
   expected[13] = a + simm;
   new_program();
   load_const(r_a, a);
   load_const(r_b, b);
   for (int k = 0; k < 14; k++) begin
      append(ops[k[3:0]]);
      append(store_word(r_res, base + k));
   end
   exit_call();
   run_program(done);
   if (done) begin
      for (int k = 0; k < 14; k++) begin
         check_value($sformatf("dmem[%0d]", base + k), mem_word(base + k), expected[k[3:0]]);
      end
   end
endtask

task automatic load_store_test();
   word_t r;
   bit    done;
   r = next_random();
   new_program();
   append(itype_word(op_lw, r_zero, r_a, 16'(16 * 4)));
   append(itype_word(op_addiu, r_a, r_a, r[15:0]));
   append(store_word(r_a, 40));
   append(itype_word(op_lw, r_zero, r_b, 16'(17 * 4)));
   append(itype_word(op_addiu, r_b, r_b, 16'hffff));  // minus one
   append(store_word(r_b, 41));
   append(itype_word(op_lui, r_zero, r_res, r[31:16]));
   append(store_word(r_res, 42));
   append(itype_word(op_addiu, r_zero, r_mark, 16'd80));  // base reg, word 20
   append(itype_word(op_lw, r_mark, r_a, 16'd8));         // word 22
   append(itype_word(op_sw, r_mark, r_a, 16'hfffc));      // word 19, negative offset
   exit_call();
   run_program(done);
   if (done) begin
      check_value("dmem[40]", mem_word(40), data_fill(16) + {{16{r[15]}}, r[15:0]});
      check_value("dmem[41]", mem_word(41), data_fill(17) - 32'd1);
      check_value("dmem[42]", mem_word(42), {r[31:16], 16'h0000});
      check_value("dmem[19]", mem_word(19), data_fill(22));
      check_value("dmem[43]", mem_word(43), data_fill(43));  // untouched
   end
endtask

// markers show which paths ran, unmarked words keep their preset
task automatic control_flow_test();
   word_t mark;
   bit    done;
   mark = 32'h0000_0a5c;
   new_program();
   append(itype_word(op_addiu, r_zero, r_a, 16'd5));       // 0
   append(itype_word(op_addiu, r_zero, r_b, 16'd5));       // 1
   append(itype_word(op_addiu, r_zero, r_res, 16'd7));     // 2
   append(itype_word(op_addiu, r_zero, r_mark, mark[15:0]));
   append(itype_word(op_beq, r_a, r_b, 16'd1));            // 4, taken
   append(store_word(r_mark, 50));
   append(store_word(r_mark, 51));
   append(itype_word(op_beq, r_a, r_res, 16'd1));          // 7, falls through
   append(store_word(r_mark, 52));
   append(itype_word(op_bne, r_a, r_res, 16'd1));          // 9, taken
   append(store_word(r_mark, 53));
   append(itype_word(op_bne, r_a, r_b, 16'd1));            // 11, falls through
   append(store_word(r_mark, 54));
   append(jump_word(op_j, text_addr(15)));                 // 13
   append(store_word(r_mark, 55));
   append(jump_word(op_jal, text_addr(18)));               // 15
   append(store_word(reg_ra, 57));                         // back from call
   append(jump_word(op_j, text_addr(21)));
   append(store_word(r_mark, 56));                         // 18, callee
   append(rtype_word(fn_jr, reg_ra, r_zero, r_zero, 5'd0));
   append(store_word(r_mark, 58));
   exit_call();                                            // 21
   run_program(done);
   if (done) begin
      check_value("dmem[50]", mem_word(50), data_fill(50));
      check_value("dmem[51]", mem_word(51), mark);
      check_value("dmem[52]", mem_word(52), mark);
      check_value("dmem[53]", mem_word(53), data_fill(53));
      check_value("dmem[54]", mem_word(54), mark);
      check_value("dmem[55]", mem_word(55), data_fill(55));
      check_value("dmem[56]", mem_word(56), mark);
      check_value("dmem[57]", mem_word(57), text_addr(15) + 32'd4);  // link = jal + 4
      check_value("dmem[58]", mem_word(58), data_fill(58));
   end
endtask

task automatic syscall_exit_test();
   bit done;
   new_program();
   append(itype_word(op_addiu, r_zero, r_a, 16'h0077));
   append(store_word(r_a, 60));
   exit_call();  // syscall in slot 3
   append(store_word(r_a, 61));
   append(store_word(r_a, 62));
   run_program(done);
   if (done) begin
      repeat (5) @(negedge clk);  // core must stay put
      check_value("dmem[60]", mem_word(60), 32'h0000_0077);
      check_value("dmem[61]", mem_word(61), data_fill(61));
      check_value("dmem[62]", mem_word(62), data_fill(62));
      check_value("inst_addr", 32'(inst_addr), text_addr(3) >> 2);
      check_value("halted", 32'(halted), 32'd1);
   end
endtask

task automatic syscall_continue_test();
   bit done;
   new_program();
   append(itype_word(op_addiu, r_zero, reg_v0, 16'd4));  // not the exit code
   append(rtype_word(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
   append(itype_word(op_addiu, r_zero, r_a, 16'h0033));
   append(store_word(r_a, 70));
   exit_call();  // real exit in slot 5
   run_program(done);
   if (done) begin
      check_value("dmem[70]", mem_word(70), 32'h0000_0033);
      check_value("inst_addr", 32'(inst_addr), text_addr(5) >> 2);
   end
endtask

task automatic reserved_inst_test();
   bit done;
   new_program();
   append(itype_word(op_addiu, r_zero, r_a, 16'h0055));
   append(store_word(r_a, 80));
   append(32'hec00_0000);  // opcode 0x3b, undefined
   append(store_word(r_a, 81));
   run_program(done);
   if (done) begin
      check_value("dmem[80]", mem_word(80), 32'h0000_0055);
      check_value("dmem[81]", mem_word(81), data_fill(81));
      check_value("inst_addr", 32'(inst_addr), text_addr(2) >> 2);
   end
endtask

// ==== dv/mips_tb.sv ====
`timescale 1ns/10ps

module mips_tb;
   import mips_pkg::*;

   localparam word_t    text_start   = 32'h0040_0000;
   localparam int       mem_words    = 256;
   localparam int       halt_timeout = 500;  // cycles per program
   localparam reg_idx_t r_zero = 5'd0;
   localparam reg_idx_t r_a    = 5'd8;   // $t0
   localparam reg_idx_t r_b    = 5'd9;
   localparam reg_idx_t r_res  = 5'd10;
   localparam reg_idx_t r_mark = 5'd11;

   logic       clk = 1'b0;
   logic       rst_b;
   word_t      inst, mem_data_out, mem_data_in;
   waddr_t     inst_addr, mem_addr;
   waddr_t     iword;  // word offset into program
   logic [3:0] mem_write_en;
   logic       halted;

   word_t imem [mem_words];
   word_t dmem [mem_words] = '{default: 32'h0};
   int    prog_len;   // next free program slot
   word_t lcg_state;
   int    errors;
   int    checks;

   always #5 clk = ~clk;

   mips_core #(.text_start(text_start)) uut (
      .clk, .rst_b, .inst, .mem_data_out,
      .inst_addr, .mem_addr, .mem_data_in, .mem_write_en, .halted
   );

   function automatic word_t next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // preset data, both bytes of the index show up
   function automatic word_t data_fill(int idx);
      return {16'hd00d, ~idx[7:0], idx[7:0]};
   endfunction

   function automatic word_t unused_inst(int idx);
      return {6'h3f, 18'h0, idx[7:0]};  // reserved opcode, tagged with slot
   endfunction

   function automatic word_t rtype_word(funct_t fn, reg_idx_t rs, reg_idx_t rt,
                                        reg_idx_t rd, logic [4:0] sh);
      return {op_rtype, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t itype_word(opcode_t op, reg_idx_t rs, reg_idx_t rt,
                                        logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t jump_word(opcode_t op, word_t dest);
      return {op, dest[27:2]};  // word target, top nibble from pc
   endfunction

   function automatic word_t text_addr(int idx);
      return text_start + 32'(idx * 4);
   endfunction

   function automatic word_t store_word(reg_idx_t rt, int slot);
      return itype_word(op_sw, r_zero, rt, 16'(slot * 4));  // absolute, base $zero
   endfunction

   function automatic word_t mem_word(int idx);
      return dmem[8'(idx)];
   endfunction

   // instruction memory, anything past the image is a reserved opcode
   assign iword = inst_addr - text_start[31:2];
   assign inst  = (iword < 30'(mem_words)) ? imem[iword[7:0]] : 32'hffff_ffff;

   assign mem_data_out = dmem[mem_addr[7:0]];  // same-cycle read

   // stores commit at the edge, preset instead while in reset
   always @(posedge clk) begin
      if (!rst_b) begin
         for (int i = 0; i < mem_words; i++) begin
            dmem[8'(i)] <= data_fill(i);
         end
      end else if (mem_write_en == 4'hf) begin
         dmem[mem_addr[7:0]] <= mem_data_in;
      end
   end

   task automatic check_value(string name, word_t got, word_t expected);
      checks++;
      if (got !== expected) begin
         $display("FAIL %0t %s: got %h, expected %h", $time, name, got, expected);
         errors++;
      end
   endtask

   task automatic append(word_t w);
      imem[8'(prog_len)] = w;
      prog_len++;
   endtask

   task automatic load_const(reg_idx_t r, word_t v);
      append(itype_word(op_lui, r_zero, r, v[31:16]));
      append(itype_word(op_ori, r, r, v[15:0]));
   endtask

   task automatic exit_call();
      append(itype_word(op_addiu, r_zero, reg_v0, 16'd10));  // $v0 = 10
      append(rtype_word(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
   endtask

   // wipe program memory, then reset the core
   task automatic new_program();
      for (int i = 0; i < mem_words; i++) begin
         imem[8'(i)] = unused_inst(i);
      end
      prog_len = 0;
      @(posedge clk);
      rst_b <= 1'b0;
   endtask

   task automatic run_program(output bit done);
      int cyc;
      repeat (4) @(posedge clk);  // reset held 4 cycles
      rst_b <= 1'b1;
      done = 1'b0;
      cyc  = 0;
      while (!done && cyc < halt_timeout) begin
         @(negedge clk);  // halted settled by now
         if (halted)
            done = 1'b1;
         else
            cyc++;
      end
      if (!done) begin
         $display("timeout: core still running after %0d cycles", halt_timeout);
         errors++;
      end
   endtask

   `include "mips_tests.svh"

   initial begin
      rst_b     <= 1'b0;
      errors    = 0;
      checks    = 0;
      prog_len  = 0;
      lcg_state = 32'h44d8_2fd4;
      repeat (4) alu_ops_test();  // new operands each pass
      load_store_test();
      control_flow_test();
      syscall_exit_test();
      syscall_continue_test();
      reserved_inst_test();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+dv
hdl/mips_pkg.sv
hdl/mips_decode.sv
hdl/mips_alu.sv
hdl/mips_regfile.sv
hdl/mips_pc_unit.sv
hdl/mips_core.sv
dv/mips_core_props.sv
dv/mips_tb.sv

// ==== run.sh ====
#!/bin/sh
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert --top-module mips_tb -f vlog.f -o mips_sim \
   && ./obj_dir/mips_sim > "$LOG" 2>&1 \
   || { cat "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }
cat "$LOG"
grep -q "TESTBENCH FAILED" "$LOG" && { echo "simulation reported failure"; exit 1; }
grep -q "TESTBENCH PASSED" "$LOG" || { echo "simulation ended without a result"; exit 1; }
exit 0
